//--- bench/irq_patterns.mem
// test irq mie gie tw priv rv instr err lsu dbg chk exp_ack exp_id exp_sleep
// chk bits 1 ack, 2 id, 4 sleep, 8 random irq; priv 3 is M, 0 is U
1 ffffffff 00000000 1 0 3 0 00000000 0 0 0 1 0 00 0
1 0000f777 00000000 1 0 3 0 00000000 0 0 0 1 0 00 0
1 00000000 00000000 1 0 3 0 00000000 0 0 0 1 0 00 0
2 00000888 ffffffff 1 0 3 0 00000000 0 0 0 0 0 00 0
2 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
2 00000088 ffffffff 1 0 3 0 00000000 0 0 0 3 1 0b 0
2 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
2 0000f7f7 ffffffff 1 0 3 0 00000000 0 0 0 3 1 03 0
2 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
2 80010800 ffffffff 1 0 3 0 00000000 0 0 0 3 1 07 0
2 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
2 00000000 ffffffff 1 0 3 0 00000000 0 0 0 3 1 1f 0
3 00000800 ffffffff 0 0 3 0 00000000 0 0 0 1 0 00 0
3 00000800 ffffffff 0 0 3 0 00000000 0 0 0 1 0 00 0
3 00000000 ffffffff 0 0 3 0 00000000 0 0 0 1 0 00 0
3 00000000 ffffffff 0 0 3 0 00000000 0 0 0 1 0 00 0
3 00000008 ffffffff 0 0 0 0 00000000 0 0 0 1 0 00 0
3 00000000 ffffffff 0 0 0 0 00000000 0 0 0 1 0 00 0
3 00020000 ffffffff 1 0 3 0 00000000 0 0 0 3 1 03 0
3 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
3 00000000 ffffffff 1 0 3 0 00000000 0 0 0 3 1 11 0
4 00000080 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
4 00000080 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
4 00000080 ffffffff 1 0 3 0 00000000 0 0 0 3 1 07 0
4 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
4 00000000 ffffffff 1 0 3 0 00000000 0 0 0 3 1 07 0
4 00000000 ffffffff 1 0 3 0 00000000 0 0 0 1 0 00 0
5 00000000 00000000 0 0 3 1 10500073 0 0 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 0 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 0 1 4 0 00 1
5 00000000 00000000 0 0 3 1 10500073 1 0 0 4 0 00 0
5 00000000 00000000 0 1 0 1 10500073 0 0 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 0 0 4 0 00 0
5 00000000 00000000 0 0 3 1 10500073 0 1 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 1 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 0 0 4 0 00 0
5 00000000 00000000 0 0 3 0 00000000 0 0 0 4 0 00 1
6 00000800 00000800 0 0 3 0 00000000 0 0 0 5 0 00 1
6 00000800 00000800 0 0 3 0 00000000 0 0 0 5 0 00 1
6 00000000 00000800 0 0 3 1 10500073 0 0 0 5 0 00 0
6 00000000 00000800 0 0 3 0 00000000 0 0 0 5 0 00 0
6 00000000 00000800 0 0 3 1 10500073 0 0 0 4 0 00 0
6 00000000 00000800 0 0 3 0 00000000 0 0 0 4 0 00 0
6 00000000 00000800 0 0 3 0 00000000 0 0 1 4 0 00 1
6 00000000 00000800 0 0 3 0 00000000 0 0 0 4 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 8 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 8 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 8 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 8 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 8 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 0 0 00 0
7 00000000 ffffffff 1 0 3 0 00000000 0 0 0 0 0 00 0

//--- bench/tb_irq_ctrl.sv
/*
  Testbench for the interrupt and sleep controller.
  Plays back the step file one line per cycle, keeps a reference model
  of mip, acknowledge, interrupt number and sleep, checks the DUT against
  both, and bounds the run with a cycle counter.
*/
`timescale 1ns/1ps

module tb_irq_ctrl;

  import irq_pkg::*;

  localparam int unsigned SLEEP_DELAY = 1;
  // Words per step line, and room for the whole step file
  localparam int unsigned COLS      = 15;
  localparam int unsigned MAX_STEPS = 64;
  // Implemented lines 31..16, 11, 7, 3
  localparam logic [31:0] VALID_LINES = 32'hffff_0888;
  localparam logic [31:0] WFI_WORD    = 32'h1050_0073;

  logic        clk;
  logic        rst_n;
  logic [31:0] irq;
  logic [31:0] mie;
  logic        gie;
  logic        tw;
  priv_lvl_e   priv;
  logic        rv;
  logic [31:0] instr;
  logic        err;
  logic        lsu;
  logic [1:0]  fetch;
  logic        dbg;
  logic [31:0] mip_o;
  logic        irq_ack_o;
  irq_id_t     irq_id_o;
  logic        core_sleep_o;

  // Step file, flat, COLS words per step
  logic [31:0] pat [0:MAX_STEPS*COLS-1];
  int          num_steps;
  int          cycle_cnt;
  int          cycle_limit;
  logic [31:0] rng;

  // Reference model state
  logic [31:0] m_mip;
  logic        m_ack;
  irq_id_t     m_id;
  logic        m_wait;
  logic        m_sleep;
  int          m_idle_run;

  // Bookkeeping
  int          cur_test;
  int          test_errs;
  int          total_errs;
  int          n_checks;
  int          tests_passed;
  int          tests_failed;

  irq_ctrl_top #(
    .SLEEP_DELAY (SLEEP_DELAY)
  ) dut (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .irq_i               (irq),
    .mie_i               (mie),
    .mstatus_mie_i       (gie),
    .mstatus_tw_i        (tw),
    .priv_lvl_i          (priv),
    .retire_valid_i      (rv),
    .retire_instr_i      (instr),
    .retire_err_i        (err),
    .lsu_busy_i          (lsu),
    .fetch_outstanding_i (fetch),
    .debug_req_i         (dbg),
    .mip_o               (mip_o),
    .irq_ack_o           (irq_ack_o),
    .irq_id_o            (irq_id_o),
    .core_sleep_o        (core_sleep_o)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  // Run limit, counted in clock cycles
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not end within %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic string test_name(input int n);
    case (n)
      1: return "pending_mirror";
      2: return "priority";
      3: return "take_rule";
      4: return "pulse_rule";
      5: return "wfi_sleep";
      6: return "wakeup";
      7: return "random_priority";
      default: return "unknown";
    endcase
  endfunction

  // Highest line by the order 31..16, then 11, 3, 7; -1 if none
  function automatic int pick_winner(input logic [31:0] req);
    for (int i = 31; i >= 16; i--) begin
      if (req[i]) return i;
    end
    if (req[11]) return 11;
    if (req[3]) return 3;
    if (req[7]) return 7;
    return -1;
  endfunction

  // One clock edge of the reference model, inputs of the cycle just ended
  task automatic model_step();
    int   win;
    logic take;
    logic ack_next;
    logic wake;
    logic legal;
    logic idle;
    logic wait_next;
    logic sleep_next;
    win  = pick_winner(m_mip & mie);
    take = (win >= 0) && ((priv == PRIV_U) || ((priv == PRIV_M) && gie));
    // Holdoff of one cycle after each acknowledge
    ack_next = take && !m_ack;
    if (ack_next) begin
      m_id = irq_id_t'(win);
    end
    // Wake ignores the global enable
    wake  = (|(m_mip & mie)) || dbg;
    legal = rv && (instr == WFI_WORD) && !err && !((priv == PRIV_U) && tw);
    idle  = m_wait && !lsu && (fetch == 2'd0) && !wake;
    if (wake) wait_next = 1'b0;
    else if (legal) wait_next = 1'b1;
    else wait_next = m_wait;
    if (wake || !m_wait) sleep_next = 1'b0;
    else if (idle && (m_idle_run + 1 >= SLEEP_DELAY)) sleep_next = 1'b1;
    else sleep_next = m_sleep;
    m_idle_run = idle ? m_idle_run + 1 : 0;
    m_mip   = irq & VALID_LINES;
    m_ack   = ack_next;
    m_wait  = wait_next;
    m_sleep = sleep_next;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("** Error %s: %s expected %h actual %h", test_name(cur_test), what, exp, act);
      test_errs++;
    end
  endtask

  // Model on every cycle, step expectations where the step asks for them
  task automatic compare_outputs(input int b);
    logic [31:0] chk;
    chk = pat[b+11];
    check_value("mip", m_mip, mip_o);
    check_value("ack", 32'(m_ack), 32'(irq_ack_o));
    check_value("irq id", 32'(m_id), 32'(irq_id_o));
    check_value("sleep", 32'(m_sleep), 32'(core_sleep_o));
    if (chk[0]) check_value("step ack", pat[b+12], 32'(irq_ack_o));
    if (chk[1]) check_value("step irq id", pat[b+13], 32'(irq_id_o));
    if (chk[2]) check_value("step sleep", pat[b+14], 32'(core_sleep_o));
  endtask

  task automatic apply_step(input int b);
    logic [31:0] chk;
    chk   = pat[b+11];
    irq   = pat[b+1];
    // Random filler requests replace the file word
    if (chk[3]) begin
      rng = xorshift32(rng);
      irq = rng;
    end
    mie   = pat[b+2];
    gie   = pat[b+3][0];
    tw    = pat[b+4][0];
    priv  = priv_lvl_e'(pat[b+5][1:0]);
    rv    = pat[b+6][0];
    instr = pat[b+7];
    err   = pat[b+8][0];
    lsu   = pat[b+9][0];
    dbg   = pat[b+10][0];
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      $display("Test %0d %s: pass", cur_test, test_name(cur_test));
      tests_passed++;
    end else begin
      $display("Test %0d %s: FAIL with %0d errors", cur_test, test_name(cur_test), test_errs);
      tests_failed++;
    end
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // --------------------------------------------------------------------------
  // Playback
  // --------------------------------------------------------------------------

  initial begin
    int b;
    clk = 1'b0;
    rst_n = 1'b0;
    irq = '0;
    mie = '0;
    gie = 1'b0;
    tw = 1'b0;
    priv = PRIV_M;
    rv = 1'b0;
    instr = '0;
    err = 1'b0;
    lsu = 1'b0;
    fetch = 2'd0;
    dbg = 1'b0;
    rng = 32'h4473e47d;
    m_mip = '0;
    m_ack = 1'b0;
    m_id = '0;
    m_wait = 1'b0;
    m_sleep = 1'b0;
    m_idle_run = 0;
    cycle_cnt = 0;
    cycle_limit = MAX_STEPS * 4 + 50;
    test_errs = 0;
    total_errs = 0;
    n_checks = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int k = 0; k < MAX_STEPS * COLS; k++) begin
      pat[k] = '0;
    end
    $readmemh("bench/irq_patterns.mem", pat);
    // Test numbers start at 1, an empty slot ends the file
    num_steps = 0;
    while ((num_steps < MAX_STEPS) && (pat[num_steps*COLS] != 0)) begin
      num_steps++;
    end
    cycle_limit = num_steps * 4 + 50;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    cur_test = int'(pat[0]);
    for (int j = 0; j < num_steps; j++) begin
      @(posedge clk);
      model_step();
      #1;
      b = j * COLS;
      if (int'(pat[b]) != cur_test) begin
        finish_test();
        cur_test = int'(pat[b]);
      end
      compare_outputs(b);
      apply_step(b);
    end
    finish_test();
    $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, n_checks, total_errs);
    if (total_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- design/irq_arbiter.sv
/*
  Interrupt arbiter.
  Selects the winning enabled pending line by fixed priority,
  applies the privilege and global-enable take rule and issues
  a registered single-cycle acknowledge with the interrupt number.
*/
`timescale 1ns/1ps

module irq_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [31:0]        mip_i,
  input  logic [31:0]        mie_i,
  input  logic               mstatus_mie_i,
  input  irq_pkg::priv_lvl_e priv_lvl_i,
  output logic               irq_ack_o,
  output irq_pkg::irq_id_t   irq_id_o
);

  import irq_pkg::*;

  // Lines that are both pending and locally enabled
  logic [NUM_IRQ-1:0] pend_en;

  // Current winner
  logic    win_valid;
  irq_id_t win_id;

  // Take decision and the acknowledge it leads to
  logic    take;
  logic    issue;

  // Acknowledge pulse and the number it carries
  logic    ack_q;
  irq_id_t id_q;

  assign pend_en = mip_i & mie_i;

  // --------------------------------------------------------------------------
  // Fixed priority
  // --------------------------------------------------------------------------

  // Order from high to low: 31..16, 11, 3, 7
  // Lines are visited from lowest to highest priority so that a later
  // hit overrides an earlier one
  always_comb begin
    win_valid = 1'b0;
    win_id    = '0;
    if (pend_en[7]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(7);
    end
    if (pend_en[3]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(3);
    end
    if (pend_en[11]) begin
      win_valid = 1'b1;
      win_id    = irq_id_t'(11);
    end
    // Platform lines, higher number wins
    for (int i = 16; i < NUM_IRQ; i++) begin
      if (pend_en[i]) begin
        win_valid = 1'b1;
        win_id    = irq_id_t'(i);
      end
    end
  end

  // --------------------------------------------------------------------------
  // Take rule and acknowledge
  // --------------------------------------------------------------------------

  // M mode needs mstatus.MIE, U mode is always interruptible by M
  assign take = win_valid &&
                (((priv_lvl_i == PRIV_M) && mstatus_mie_i) || (priv_lvl_i == PRIV_U));

  // No back-to-back acknowledge, a held request gets every second cycle
  assign issue = take && !ack_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
      id_q  <= '0;
    end else begin
      ack_q <= issue;
      // Number is held between acknowledges
      if (issue) begin
        id_q <= win_id;
      end
    end
  end

  assign irq_ack_o = ack_q;
  assign irq_id_o  = id_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Acknowledge is a pulse
  a_ack_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |=> !irq_ack_o
  );

  // Acknowledged number is an implemented line
  a_ack_id_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> IRQ_VALID_MASK[irq_id_o]
  );

  // Acknowledged line was enabled when it was selected
  a_ack_id_enabled: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    irq_ack_o |-> |($past(mie_i) & (32'h1 << irq_id_o))
  );

endmodule

//--- design/irq_ctrl_top.sv
/*
  Interrupt and sleep controller top level.
  Connects the pending register, the arbiter and the WFI block
  and passes the sleep delay down.
*/
`timescale 1ns/1ps

module irq_ctrl_top #(
  parameter int unsigned SLEEP_DELAY = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Interrupt requests and CSR state
  input  logic [31:0]        irq_i,
  input  logic [31:0]        mie_i,
  input  logic               mstatus_mie_i,
  input  logic               mstatus_tw_i,
  input  irq_pkg::priv_lvl_e priv_lvl_i,
  // Writeback stage
  input  logic               retire_valid_i,
  input  logic [31:0]        retire_instr_i,
  input  logic               retire_err_i,
  // Pipeline activity and debug
  input  logic               lsu_busy_i,
  input  logic [1:0]         fetch_outstanding_i,
  input  logic               debug_req_i,
  // Results
  output logic [31:0]        mip_o,
  output logic               irq_ack_o,
  output irq_pkg::irq_id_t   irq_id_o,
  output logic               core_sleep_o
);

  import isa_pkg::*;

  // Pending and enabled, towards the WFI block
  logic        wake;

  // Retiring word as it arrives, decoded inside wfi_ctrl
  instr_word_u retire_instr;

  assign retire_instr.raw = retire_instr_i;

  // --------------------------------------------------------------------------
  // Blocks
  // --------------------------------------------------------------------------

  irq_pending u_pending (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .irq_i  (irq_i),
    .mie_i  (mie_i),
    .mip_o  (mip_o),
    .wake_o (wake)
  );

  irq_arbiter u_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .mip_i         (mip_o),
    .mie_i         (mie_i),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_lvl_i    (priv_lvl_i),
    .irq_ack_o     (irq_ack_o),
    .irq_id_o      (irq_id_o)
  );

  wfi_ctrl #(
    .SLEEP_DELAY (SLEEP_DELAY)
  ) u_wfi (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .retire_valid_i      (retire_valid_i),
    .retire_instr_i      (retire_instr),
    .retire_err_i        (retire_err_i),
    .priv_lvl_i          (priv_lvl_i),
    .mstatus_tw_i        (mstatus_tw_i),
    .lsu_busy_i          (lsu_busy_i),
    .fetch_outstanding_i (fetch_outstanding_i),
    .wake_i              (wake),
    .debug_req_i         (debug_req_i),
    .core_sleep_o        (core_sleep_o)
  );

endmodule

//--- design/irq_pending.sv
/*
  Interrupt pending register.
  Samples the request lines into mip with reserved lines cleared
  and flags a pending and enabled line as a wakeup condition.
*/
`timescale 1ns/1ps

module irq_pending (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic [31:0] irq_i,
  input  logic [31:0] mie_i,
  output logic [31:0] mip_o,
  output logic        wake_o
);

  import irq_pkg::*;

  // Registered request word, reserved lines already dropped
  logic [NUM_IRQ-1:0] mip_q;

  // --------------------------------------------------------------------------
  // Pending register
  // --------------------------------------------------------------------------

  // One cycle of latency from irq_i to mip
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
    end else begin
      mip_q <= irq_i & IRQ_VALID_MASK;
    end
  end

  assign mip_o = mip_q;

  // Wake ignores mstatus.MIE and privilege
  // WFI must resume even when the interrupt itself is not taken
  assign wake_o = |(mip_q & mie_i);

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // A request on a reserved line never shows up in mip
  a_mip_no_reserved: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    |(irq_i & ~IRQ_VALID_MASK) |=> ((mip_o & ~IRQ_VALID_MASK) == '0)
  );

endmodule

//--- design/irq_pkg.sv
/*
  Interrupt numbering shared by the controller blocks.
  Holds the line count, the implemented-line mask, the interrupt
  number type and the privilege levels used by the take rule.
*/
package irq_pkg;

  // --------------------------------------------------------------------------
  // Request lines
  // --------------------------------------------------------------------------

  // All lines on irq_i, reserved ones included
  localparam int unsigned NUM_IRQ = 32;

  // Implemented lines
  // 31..16 platform, 11 machine external, 7 machine timer, 3 machine software
  localparam logic [NUM_IRQ-1:0] IRQ_VALID_MASK = 32'hffff_0888;

  // --------------------------------------------------------------------------
  // Interrupt number
  // --------------------------------------------------------------------------

  // Enough bits to name any of the NUM_IRQ lines
  localparam int unsigned IRQ_ID_W = 5;

  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  // --------------------------------------------------------------------------
  // Privilege
  // --------------------------------------------------------------------------

  // Encoding follows the mstatus.MPP field
  // Only M and U are implemented on this core
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

endpackage

//--- design/isa_pkg.sv
/*
  Instruction word views and SYSTEM encodings.
  Holds the packed union over a retiring instruction word
  and the field constants that identify WFI.
*/
package isa_pkg;

  // --------------------------------------------------------------------------
  // Instruction word
  // --------------------------------------------------------------------------

  // One 32-bit word, seen raw or split as an I-type instruction
  // The raw view is what arrives from writeback
  // The field view is what the WFI decoder compares
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      // imm[11:0], holds the function code for SYSTEM
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } itype;
  } instr_word_u;

  // --------------------------------------------------------------------------
  // SYSTEM encodings
  // --------------------------------------------------------------------------

  // Major opcode shared by ECALL, EBREAK, xRET, WFI and the CSR ops
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // funct3 of the privileged group, as opposed to CSR accesses
  localparam logic [2:0] F3_PRIV = 3'b000;

  // funct12 that selects WFI inside the privileged group
  localparam logic [11:0] F12_WFI = 12'h105;

  // x0, required in both rs1 and rd of WFI
  localparam logic [4:0] REG_ZERO = 5'd0;

endpackage

//--- design/wfi_ctrl.sv
/*
  WFI and sleep control.
  Recognizes a legally retiring WFI, holds the wait state until
  a wake, and raises sleep after a run of idle pipeline cycles.
*/
`timescale 1ns/1ps

module wfi_ctrl #(
  parameter int unsigned SLEEP_DELAY = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                retire_valid_i,
  input  isa_pkg::instr_word_u retire_instr_i,
  input  logic                retire_err_i,
  input  irq_pkg::priv_lvl_e  priv_lvl_i,
  input  logic                mstatus_tw_i,
  input  logic                lsu_busy_i,
  input  logic [1:0]          fetch_outstanding_i,
  input  logic                wake_i,
  input  logic                debug_req_i,
  output logic                core_sleep_o
);

  import irq_pkg::*;
  import isa_pkg::*;

  // Wide enough to hold SLEEP_DELAY-1, at least one bit
  localparam int unsigned CNT_W = $clog2(SLEEP_DELAY + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SLEEP_DELAY - 1);

  logic             is_wfi_enc;
  logic             wfi_legal;
  logic             wake;
  logic             idle;

  logic             wait_q;
  logic             sleep_q;
  logic [CNT_W-1:0] idle_cnt_q;

  // --------------------------------------------------------------------------
  // WFI decode
  // --------------------------------------------------------------------------

  // Field view of the retiring word
  // WFI is SYSTEM, privileged group, funct12 0x105, x0 in rs1 and rd
  assign is_wfi_enc = (retire_instr_i.itype.opcode  == OPC_SYSTEM) &&
                      (retire_instr_i.itype.funct3  == F3_PRIV)    &&
                      (retire_instr_i.itype.funct12 == F12_WFI)    &&
                      (retire_instr_i.itype.rs1     == REG_ZERO)   &&
                      (retire_instr_i.itype.rd      == REG_ZERO);

  // Faulting fetch or TW trap in U mode means no wait state
  assign wfi_legal = retire_valid_i && is_wfi_enc && !retire_err_i &&
                     !((priv_lvl_i == PRIV_U) && mstatus_tw_i);

  // Interrupt pending and enabled, or debug request
  assign wake = wake_i || debug_req_i;

  // Pipeline drained and nothing about to end the wait
  assign idle = wait_q && !lsu_busy_i && (fetch_outstanding_i == 2'd0) && !wake;

  // --------------------------------------------------------------------------
  // Wait state
  // --------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= 1'b0;
    end else if (wake) begin
      // Wake wins over a WFI in the same cycle
      wait_q <= 1'b0;
    end else if (wfi_legal) begin
      wait_q <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Idle count and sleep
  // --------------------------------------------------------------------------

  // Counts idle cycles already seen in this run, saturates at CNT_LAST
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idle_cnt_q <= '0;
    end else if (!idle) begin
      idle_cnt_q <= '0;
    end else if (idle_cnt_q != CNT_LAST) begin
      idle_cnt_q <= idle_cnt_q + 1'b1;
    end
  end

  // Rises the cycle after the SLEEP_DELAY-th idle cycle
  // Stays up until the wait ends
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= 1'b0;
    end else if (wake || !wait_q) begin
      sleep_q <= 1'b0;
    end else if (idle && (idle_cnt_q == CNT_LAST)) begin
      sleep_q <= 1'b1;
    end
  end

  assign core_sleep_o = sleep_q;

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------

  // Only a WFI puts the core to sleep
  a_sleep_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    core_sleep_o |-> wait_q
  );

endmodule

//--- irq_ctrl.f
design/irq_pkg.sv
design/isa_pkg.sv
design/irq_pending.sv
design/irq_arbiter.sv
design/wfi_ctrl.sv
design/irq_ctrl_top.sv
bench/tb_irq_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
# Build the irq_ctrl testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

# Build and run, stop on a build or runtime failure
verilator --binary --timing --assert -f irq_ctrl.f --top-module tb_irq_ctrl \
  --Mdir obj_dir -o tb_irq_ctrl_sim \
  && ./obj_dir/tb_irq_ctrl_sim | tee "$log" \
  || { echo "Build or simulation failed"; exit 1; }

# The result is decided by the closing line of the log
grep -qx "Done: no errors" "$log" && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
